//--- hdl/synth_pkg.sv
package synth_pkg;

   // sizes
   localparam int n_keys      = 5;
   localparam int n_switches  = 8;
   localparam int sync_stages = 3;
   localparam int key_idx_w   = $clog2(n_keys);

   // switch word fields
   localparam int wave_lsb = 0;
   localparam int wave_w   = 2;
   localparam int scale_lsb = 4;
   localparam int scale_w  = 4;

   localparam int sample_w = 8;
   localparam int phase_w  = 8;

   localparam int pwm_frame  = 256;
   localparam int pwm_cnt_w  = $clog2(pwm_frame);
   localparam int pwm_offset = 127; // centres a signed sample in the frame
   localparam int square_amp = 100;

   typedef logic [3:0]                 semitone_t; // 0 to 12 above the root
   typedef logic signed [sample_w-1:0] sample_t;
   typedef logic [scale_w-1:0]         scale_sel_t;
   typedef logic [phase_w-1:0]         phase_t;

   typedef enum logic [wave_w-1:0] {
      wave_square = 2'd0,
      wave_saw    = 2'd1,
      wave_tri    = 2'd2,
      wave_mute   = 2'd3
   } wave_sel_t;

endpackage

//--- hdl/scale_pkg.sv
package scale_pkg;

   import synth_pkg::*;

   localparam int n_scales    = 16;
   localparam int n_semitones = 13;

   // five scale degrees per select code, as semitones above the root
   localparam semitone_t scale_table [n_scales][n_keys] = '{
      '{4'd0, 4'd3, 4'd5, 4'd7,  4'd10},
      '{4'd0, 4'd3, 4'd7, 4'd10, 4'd12},
      '{4'd0, 4'd3, 4'd5, 4'd7,  4'd8},
      '{4'd2, 4'd4, 4'd6, 4'd7,  4'd9},
      '{4'd0, 4'd2, 4'd3, 4'd5,  4'd8},
      '{4'd0, 4'd2, 4'd7, 4'd9,  4'd10},
      '{4'd0, 4'd2, 4'd3, 4'd5,  4'd7},
      '{4'd0, 4'd2, 4'd4, 4'd6,  4'd7},
      '{4'd2, 4'd4, 4'd5, 4'd7,  4'd8},
      '{4'd0, 4'd3, 4'd5, 4'd7,  4'd9},
      '{4'd3, 4'd5, 4'd7, 4'd8,  4'd12},
      '{4'd0, 4'd4, 4'd7, 4'd11, 4'd12},
      '{4'd0, 4'd2, 4'd4, 4'd7,  4'd9},
      '{4'd2, 4'd3, 4'd7, 4'd8,  4'd10},
      '{4'd5, 4'd7, 4'd9, 4'd11, 4'd12},
      '{4'd0, 4'd2, 4'd4, 4'd5,  4'd7}
   };

   // phase step per frame for each semitone, roughly equal tempered
   localparam phase_t phase_inc_table [n_semitones] = '{
      8'd16, // root
      8'd17,
      8'd18,
      8'd19,
      8'd20,
      8'd21,
      8'd22,
      8'd24, // fifth
      8'd25,
      8'd27,
      8'd28,
      8'd30,
      8'd32  // octave, twice the root
   };

endpackage

//--- hdl/input_sync.sv
`timescale 1ns/10ps

module input_sync
   import synth_pkg::*;
(
   input  logic                  clk,
   input  logic                  rstn,
   input  logic [n_switches-1:0] sw,
   input  logic [n_keys-1:0]     note_enn,
   output logic [n_switches-1:0] sw_sync,
   output logic [n_keys-1:0]     key_on
);

   logic [n_switches-1:0] sw_q  [sync_stages];
   logic [n_keys-1:0]     key_q [sync_stages];

   always_ff @(posedge clk or negedge rstn)
   begin
      if (!rstn)
      begin
         for (int i = 0; i < sync_stages; i++)
         begin
            sw_q[i]  <= '0;
            key_q[i] <= '1; // keys released
         end
      end
      else
      begin
         sw_q[0]  <= sw;
         key_q[0] <= note_enn;
         for (int i = 1; i < sync_stages; i++)
         begin
            sw_q[i]  <= sw_q[i-1];
            key_q[i] <= key_q[i-1];
         end
      end
   end

   assign sw_sync = sw_q[sync_stages-1];
   assign key_on  = ~key_q[sync_stages-1]; // pressed reads as 1

endmodule

//--- hdl/note_select.sv
`timescale 1ns/10ps

module note_select
   import synth_pkg::*, scale_pkg::*;
(
   input  scale_sel_t        scale_sel,
   input  logic [n_keys-1:0] key_on,
   output semitone_t         semitone,
   output logic              gate
);

   logic [key_idx_w-1:0] key_idx;
   semitone_t            scale_row [n_keys];

   // lowest index wins, scanned from the top so the last hit stays
   always_comb
   begin
      key_idx = '0;
      for (int i = n_keys - 1; i >= 0; i--)
      begin
         if (key_on[i])
         begin
            key_idx = key_idx_w'(i);
         end
      end
   end

   assign gate = |key_on;

   // row of five degrees for the selected scale
   always_comb
   begin
      for (int k = 0; k < n_keys; k++)
      begin
         scale_row[k] = scale_table[scale_sel][k];
      end
   end

   assign semitone = scale_row[key_idx]; // key 0 when nothing pressed

endmodule

//--- hdl/tone_gen.sv
`timescale 1ns/10ps

module tone_gen
   import synth_pkg::*, scale_pkg::*;
(
   input  logic      clk,
   input  logic      rstn,
   input  semitone_t semitone,
   input  logic      gate,
   input  wave_sel_t wave_sel,
   input  logic      frame_strobe,
   output sample_t   sample
);

   phase_t  phase;
   phase_t  phase_inc;
   phase_t  tri_fold;
   sample_t square_s;
   sample_t saw_s;
   sample_t tri_s;

   assign phase_inc = phase_inc_table[semitone];

   // one step per pwm frame, restart from zero on release
   always_ff @(posedge clk or negedge rstn)
   begin
      if (!rstn)
      begin
         phase <= '0;
      end
      else if (frame_strobe)
      begin
         if (gate)
            phase <= phase + phase_inc;
         else
            phase <= '0;
      end
   end

   assign square_s = phase[7] ? -sample_t'(square_amp) : sample_t'(square_amp);

   // p - 128, with p = 0 lifted so the duty never goes below zero
   assign saw_s = (phase == '0) ? -sample_t'(pwm_offset)
                                : sample_t'({~phase[7], phase[6:0]});

   // upper half mirrored onto the lower half, then 2q - 127
   assign tri_fold = phase[7] ? ~phase : phase;
   assign tri_s    = sample_t'({tri_fold[6:0], 1'b0} - 8'd127);

   always_comb
   begin
      sample = '0;
      if (gate)
      begin
         case (wave_sel)
            wave_square: sample = square_s;
            wave_saw:    sample = saw_s;
            wave_tri:    sample = tri_s;
            default:     sample = '0; // mute
         endcase
      end
   end

endmodule

//--- hdl/pwm_dac.sv
`timescale 1ns/10ps

module pwm_dac
   import synth_pkg::*;
(
   input  logic    clk,
   input  logic    rstn,
   input  sample_t sample,
   output logic    frame_strobe,
   output logic    pwm_out
);

   logic [pwm_cnt_w-1:0] frame_cnt;
   logic [pwm_cnt_w-1:0] on_cnt;
   logic [pwm_cnt_w-1:0] duty;

   // -127..127 maps to 0..254 high cycles
   assign duty = pwm_cnt_w'(unsigned'(sample)) + pwm_cnt_w'(pwm_offset);

   assign frame_strobe = (frame_cnt == pwm_cnt_w'(pwm_frame - 1));

   always_ff @(posedge clk or negedge rstn)
   begin
      if (!rstn)
         frame_cnt <= '0;
      else
         frame_cnt <= frame_cnt + 1'b1; // wraps at frame end
   end

   always_ff @(posedge clk or negedge rstn)
   begin
      if (!rstn)
      begin
         on_cnt <= '0;
      end
      else if (frame_strobe)
      begin
         on_cnt <= duty;
      end
      else if (on_cnt != '0)
      begin
         on_cnt <= on_cnt - 1'b1; // holds at zero
      end
   end

   always_ff @(posedge clk or negedge rstn)
   begin
      if (!rstn)
         pwm_out <= 1'b0;
      else
         pwm_out <= (on_cnt != '0);
   end

endmodule

//--- hdl/synth_top.sv
`timescale 1ns/10ps

module synth_top
   import synth_pkg::*;
(
   input  logic                  clk,
   input  logic                  rstn,
   input  logic [n_switches-1:0] sw,
   input  logic [n_keys-1:0]     note_enn,
   output logic                  pwm_out
);

   logic [n_switches-1:0] sw_sync;
   logic [n_keys-1:0]     key_on;
   semitone_t             semitone;
   logic                  gate;
   logic                  frame_strobe;
   sample_t               sample;

   input_sync i_input_sync (
      .clk      (clk),
      .rstn     (rstn),
      .sw       (sw),
      .note_enn (note_enn),
      .sw_sync  (sw_sync),
      .key_on   (key_on)
   );

   // bits 3:2 of the switch word are reserved
   note_select i_note_select (
      .scale_sel (scale_sel_t'(sw_sync[scale_lsb +: scale_w])),
      .key_on    (key_on),
      .semitone  (semitone),
      .gate      (gate)
   );

   tone_gen i_tone_gen (
      .clk          (clk),
      .rstn         (rstn),
      .semitone     (semitone),
      .gate         (gate),
      .wave_sel     (wave_sel_t'(sw_sync[wave_lsb +: wave_w])),
      .frame_strobe (frame_strobe),
      .sample       (sample)
   );

   pwm_dac i_pwm_dac (
      .clk          (clk),
      .rstn         (rstn),
      .sample       (sample),
      .frame_strobe (frame_strobe),
      .pwm_out      (pwm_out)
   );

endmodule

//--- verif/synth_tb_model.svh
`ifndef SYNTH_TB_MODEL_SVH
`define SYNTH_TB_MODEL_SVH

// x^16 + x^14 + x^13 + x^11 + 1, feedback enters at bit 0
function automatic logic [15:0] lfsr_step(input logic [15:0] s);
   logic fb;
   fb = s[15] ^ s[13] ^ s[12] ^ s[10];
   return {s[14:0], fb};
endfunction

// index of the first pressed key counting up, 0 when none
function automatic int lowest_key(input logic [n_keys-1:0] enn);
   int  idx;
   bit  found;
   idx   = 0;
   found = 1'b0;
   for (int i = 0; i < n_keys; i++)
   begin
      if (!enn[i] && !found)
      begin
         idx   = i;
         found = 1'b1;
      end
   end
   return idx;
endfunction

function automatic int sample_of(input int wave, input bit gate, input int p);
   if (!gate)
      return 0;
   case (wave)
      wave_square: return (p < 128) ? square_amp : -square_amp;
      wave_saw:    return (p == 0) ? -127 : p - 128;
      wave_tri:    return (p < 128) ? 2 * p - 127 : 383 - 2 * p;
      default:     return 0;
   endcase
endfunction

function automatic int duty_of(input int wave, input bit gate, input int p);
   return sample_of(wave, gate, p) + pwm_offset;
endfunction

// steps the phase one frame at a time up to the target frame
task automatic advance_model(input int target);
   while (m_frame < target)
   begin
      if (m_gate)
         m_phase = (m_phase + m_inc) % (1 << phase_w);
      else
         m_phase = 0;
      m_frame++;
   end
endtask

task automatic check_value(input string name, input int expected, input int actual);
   checks++;
   if (expected != actual)
   begin
      errors++;
      $display("MISMATCH %s: expected %0d, actual %0d", name, expected, actual);
   end
endtask

`endif

//--- verif/synth_tb.sv
`timescale 1ns/10ps

module synth_tb
   import synth_pkg::*, scale_pkg::*;
();

   localparam int clk_half_ns   = 4;
   localparam int settle_frames = 4;
   localparam int kind_idle     = 0;
   localparam int kind_tracked  = 1;
   localparam int kind_fixed    = 2;

   logic                  clk;
   logic                  rstn;
   logic [n_switches-1:0] sw;
   logic [n_keys-1:0]     note_enn;
   logic                  pwm_out;

   string                 row_name   [$];
   logic [n_switches-1:0] row_sw     [$];
   logic [n_keys-1:0]     row_enn    [$];
   int                    row_frames [$];
   int                    row_kind   [$];
   bit                    row_prio   [$];

   int          cyc = 0;
   int          frames_done = 0;
   int          high_acc = 0;
   int          duties [$];
   int          checks = 0;
   int          errors = 0;
   int          tests_failed = 0;
   bit          table_ready = 1'b0;
   logic [15:0] lfsr_state = 16'd50584;

   // expected phase of frame m_frame under the current inputs
   int m_frame = 0;
   int m_phase = 0;
   int m_inc = 0;
   int m_wave = 0;
   bit m_gate = 1'b0;

   `include "synth_tb_model.svh"

   synth_top i_dut (
      .clk      (clk),
      .rstn     (rstn),
      .sw       (sw),
      .note_enn (note_enn),
      .pwm_out  (pwm_out)
   );

   initial
   begin
      clk = 1'b0;
      forever
      begin
         #(clk_half_ns) clk = ~clk;
      end
   end

   always @(posedge clk)
   begin
      if (rstn)
         cyc <= cyc + 1; // edges since reset release
   end

   // duty per frame, sampled mid cycle
   always @(negedge clk)
   begin
      int pos;
      if (cyc <= pwm_frame)
      begin
         if (pwm_out === 1'b1)
         begin
            errors++;
            $display("pwm_out went high at cycle %0d, before the first frame", cyc);
         end
      end
      else
      begin
         pos = (cyc - 1) % pwm_frame;
         if (pos == 0)
            high_acc = 0;
         high_acc += (pwm_out === 1'b1) ? 1 : 0;
         if (pos == pwm_frame - 1)
         begin
            duties.push_back(high_acc);
            frames_done++;
         end
      end
   end

   task automatic add_row(input string name, input logic [7:0] s, input logic [4:0] enn,
                          input int frames, input int kind, input bit prio);
      row_name.push_back(name);
      row_sw.push_back(s);
      row_enn.push_back(enn);
      row_frames.push_back(frames);
      row_kind.push_back(kind);
      row_prio.push_back(prio);
   endtask

   task automatic load_table();
      add_row("reset_idle",   8'h00, 5'b11111, 4, kind_idle,    1'b0);
      add_row("saw_s0_k0",    8'h01, 5'b11110, 4, kind_tracked, 1'b0);
      add_row("saw_s5_k2",    8'h51, 5'b11011, 4, kind_tracked, 1'b0);
      add_row("saw_s10_k4",   8'hA1, 5'b01111, 4, kind_tracked, 1'b0);
      add_row("saw_s14_k3",   8'hE1, 5'b10111, 4, kind_tracked, 1'b0);
      add_row("saw_s11_k1",   8'hB1, 5'b11101, 4, kind_tracked, 1'b0);
      add_row("saw_rsvd_s2",  8'h2D, 5'b11101, 3, kind_tracked, 1'b0); // bits 3:2 set
      add_row("prio_s3_k0",   8'h31, 5'b11110, 3, kind_tracked, 1'b1);
      add_row("prio_s8_k1",   8'h81, 5'b11101, 3, kind_tracked, 1'b1);
      add_row("prio_s13_k2",  8'hD1, 5'b11011, 3, kind_tracked, 1'b1);
      add_row("prio_s1_k3",   8'h11, 5'b10111, 3, kind_tracked, 1'b1);
      add_row("square_s1_k4", 8'h10, 5'b01111, 4, kind_fixed,   1'b0);
      add_row("tri_s12_k2",   8'hC2, 5'b11011, 5, kind_fixed,   1'b0);
      add_row("tri_s6_k0",    8'h62, 5'b11110, 5, kind_fixed,   1'b0);
      add_row("square_s9_k3", 8'h90, 5'b10111, 4, kind_fixed,   1'b0);
      add_row("mute_s9_k3",   8'h93, 5'b10111, 3, kind_idle,    1'b0);
      add_row("release_all",  8'h91, 5'b11111, 3, kind_idle,    1'b0);
   endtask

   task automatic run_row(input int r);
      logic [n_keys-1:0]     enn;
      logic [n_switches-1:0] s;
      int                    fd0;
      int                    first;
      int                    err0;
      int                    p0;
      int                    semi;
      int                    win;
      enn  = row_enn[r];
      s    = row_sw[r];
      win  = lowest_key(enn);
      err0 = errors;
      fd0  = frames_done;
      @(posedge clk);
      while (frames_done == fd0)
         @(posedge clk);
      if (row_prio[r])
      begin
         // random extra keys above the winner, at least one of them
         while (enn == row_enn[r] && win < n_keys - 1)
         begin
            for (int j = win + 1; j < n_keys; j++)
            begin
               lfsr_state = lfsr_step(lfsr_state);
               if (lfsr_state[0])
                  enn[j] = 1'b0;
            end
         end
      end
      advance_model(frames_done + 1);
      semi   = scale_table[s[scale_lsb +: scale_w]][lowest_key(enn)];
      m_inc  = phase_inc_table[semi];
      m_gate = (enn != '1);
      m_wave = s[wave_lsb +: wave_w];
      sw       <= s;
      note_enn <= enn;
      first = frames_done + settle_frames;
      wait (frames_done >= first + row_frames[r]);
      case (row_kind[r])
         kind_idle:
         begin
            for (int g = first; g < first + row_frames[r]; g++)
               check_value($sformatf("%s frame %0d", row_name[r], g), pwm_offset, duties[g]);
         end
         kind_tracked:
         begin
            // duty 0 could be phase 0 or 1, so use the next frame then
            if (duties[first] != 0)
               p0 = duties[first] + 1;
            else
               p0 = (duties[first + 1] + 1 - m_inc) & 8'hff;
            advance_model(first);
            check_value({row_name[r], " phase"}, m_phase, p0);
            for (int k = 0; k < row_frames[r]; k++)
               check_value($sformatf("%s frame %0d", row_name[r], first + k),
                           duty_of(m_wave, m_gate, (p0 + k * m_inc) % 256), duties[first + k]);
         end
         default:
         begin
            for (int g = first; g < first + row_frames[r]; g++)
            begin
               advance_model(g);
               check_value($sformatf("%s frame %0d", row_name[r], g),
                           duty_of(m_wave, m_gate, m_phase), duties[g]);
            end
         end
      endcase
      if (errors == err0)
         $display("test %s: ok over %0d frames", row_name[r], row_frames[r]);
      else
      begin
         tests_failed++;
         $display("test %s: failed with %0d errors", row_name[r], errors - err0);
      end
   endtask

   initial
   begin
      sw       = '0;
      note_enn = '1;
      rstn     = 1'b0;
      load_table();
      table_ready = 1'b1;
      repeat (3) @(posedge clk);
      rstn <= 1'b1;
      for (int r = 0; r < row_name.size(); r++)
         run_row(r);
      $display("%0d tests, %0d failed, %0d checks, %0d errors",
               row_name.size(), tests_failed, checks, errors);
      if (errors == 0)
         $display("All tests passed");
      else
         $display("Some tests failed");
      $finish;
   end

   // frame budget of the whole table plus a few spare frames
   initial
   begin
      int budget;
      wait (table_ready);
      budget = 6;
      foreach (row_frames[i])
         budget += row_frames[i] + settle_frames + 1;
      #(budget * pwm_frame * 2 * clk_half_ns);
      $display("watchdog: the run did not finish within %0d frames", budget);
      $display("Some tests failed");
      $finish;
   end

endmodule

//--- sources.f
+incdir+verif
hdl/synth_pkg.sv
hdl/scale_pkg.sv
hdl/input_sync.sv
hdl/note_select.sv
hdl/tone_gen.sv
hdl/pwm_dac.sv
hdl/synth_top.sv
verif/synth_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal
TOP       ?= synth_tb
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := All tests passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
